// ==== Bender.yml ====
package:
  name: accel_spi

sources:
  - logic/accel_pkg.sv
  - logic/spi_byte_engine.sv
  - logic/accel_sampler.sv
  - logic/sample_fifo.sv
  - logic/accel_host_port.sv
  - logic/accel_spi_top.sv
  - target: simulation
    files:
      - dv/accel_sensor_model.sv
      - dv/accel_spi_assert.sv
      - dv/accel_spi_tb.sv

// ==== all.f ====
logic/accel_pkg.sv
logic/spi_byte_engine.sv
logic/accel_sampler.sv
logic/sample_fifo.sv
logic/accel_host_port.sv
logic/accel_spi_top.sv
dv/accel_sensor_model.sv
dv/accel_spi_assert.sv
dv/accel_spi_tb.sv

// ==== dv/accel_sensor_model.sv ====
`timescale 1ns/1ps

module accel_sensor_model (
   input  logic sck_i,
   input  logic mosi_i,
   input  logic ncs_i,
   output logic miso_o
);

   import accel_pkg::*;

   logic [7:0] mem [256];
   logic [7:0] shift_in = 8'h00;
   logic [7:0] out_sr   = 8'h00;
   logic [7:0] cmd      = 8'h00;
   logic [7:0] addr     = 8'h00;
   int         bit_cnt  = 0;
   int         byte_cnt = 0;

   // background contents, data registers get loaded by the testbench
   initial begin
      for (int a = 0; a < 256; a++) begin
         mem[a] = 8'(a) ^ 8'h5A;
      end
   end

   // new transaction
   always @(negedge ncs_i) begin
      bit_cnt  = 0;
      byte_cnt = 0;
   end

   // mode 0, mosi taken on the rising edge
   always @(posedge sck_i) begin
      if (ncs_i === 1'b0) begin
         shift_in = {shift_in[6:0], mosi_i};
         bit_cnt++;
         if (bit_cnt == 8) begin
            bit_cnt = 0;
            if (byte_cnt == 0) cmd = shift_in;
            else if (byte_cnt == 1) addr = shift_in;
            byte_cnt++;
         end
      end
   end

   // miso updated on the falling edge, next byte fetched at each byte boundary
   always @(negedge sck_i) begin
      if (ncs_i === 1'b0 && byte_cnt >= 2 && cmd == CMD_READ) begin
         if (bit_cnt == 0) begin
            out_sr = mem[addr];
            addr   = addr + 8'd1; // auto increment
         end else begin
            out_sr = {out_sr[6:0], 1'b0};
         end
      end
   end

   assign miso_o = (ncs_i === 1'b0) ? out_sr[7] : 1'b0;

endmodule

// ==== dv/accel_spi_assert.sv ====
`timescale 1ns/1ps

module accel_spi_assert (
   input logic clk_i,
   input logic rst_n_i,
   input logic ncs_i,
   input logic sck_i,
   input logic stb_i,
   input logic ack_i,
   input logic push_i
);

   int n_fail = 0; // failed assertions so far

   // sck idles low outside a burst
   sck_idle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) ncs_i |-> !sck_i)
      else begin
         n_fail++;
         $error("sck is high while chip select is inactive");
      end

   // one acknowledge per strobe one cycle later
   ack_after_stb_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) stb_i |=> ack_i)
      else begin
         n_fail++;
         $error("strobe was not acknowledged in the next cycle");
      end
   ack_only_after_stb_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |-> $past(stb_i))
      else begin
         n_fail++;
         $error("acknowledge without a strobe in the previous cycle");
      end

   push_in_burst_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !ncs_i)
      else begin
         n_fail++;
         $error("FIFO push while chip select is inactive");
      end

endmodule

bind accel_spi_top accel_spi_assert u_assert (
   .clk_i   (clk_i),
   .rst_n_i (rst_n_i),
   .ncs_i   (ncs_o),
   .sck_i   (sck_o),
   .stb_i   (bus_stb_i),
   .ack_i   (bus_ack_o),
   .push_i  (push)
);

// ==== dv/accel_spi_tb.sv ====
`timescale 1ns/1ps

module accel_spi_tb;

   import accel_pkg::*;

   localparam int FIFO_DEPTH    = 8;
   localparam int SAMPLE_PERIOD = 400;

   logic        clk;
   logic        rst_n;
   logic        stb;
   logic        we;
   logic [1:0]  adr;
   logic [15:0] wdata;
   logic        ack;
   logic [15:0] rdata;
   logic        irq;
   logic        sck;
   logic        mosi;
   logic        ncs;
   logic        miso;

   integer      seed;
   int          n_checks;
   int          n_err;
   int          n_tmo;
   int          n_asrt;
   logic [15:0] exp_word [3]; // X, Y, Z as the sampler should build them

   accel_spi_top #(.FIFO_DEPTH(FIFO_DEPTH), .SAMPLE_PERIOD(SAMPLE_PERIOD)) u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .bus_stb_i   (stb),
      .bus_we_i    (we),
      .bus_adr_i   (adr),
      .bus_wdata_i (wdata),
      .miso_i      (miso),
      .bus_ack_o   (ack),
      .bus_rdata_o (rdata),
      .irq_o       (irq),
      .sck_o       (sck),
      .mosi_o      (mosi),
      .ncs_o       (ncs)
   );

   accel_sensor_model u_sensor (
      .sck_i  (sck),
      .mosi_i (mosi),
      .ncs_i  (ncs),
      .miso_o (miso)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_err++;
         $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic timeout_seen(input string what);
      n_tmo++;
      $display("%0t timeout, %s", $time, what);
   endtask

   task automatic bus_write(input logic [1:0] a, input logic [15:0] d);
      @(posedge clk);
      #1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      wdata = d;
      @(posedge clk);
      #1;
      stb = 1'b0;
      we  = 1'b0;
      check_val("bus_ack_o", 16'(ack), 16'd1);
   endtask

   task automatic bus_read(input logic [1:0] a, output logic [15:0] d);
      @(posedge clk);
      #1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      @(posedge clk);
      #1;
      stb = 1'b0;
      check_val("bus_ack_o", 16'(ack), 16'd1);
      d = rdata;
   endtask

   task automatic wait_ncs(input logic val, input int limit);
      int  n;
      bit  hit;
      hit = (ncs === val);
      for (n = 0; n < limit && !hit; n++) begin
         @(posedge clk);
         #1;
         hit = (ncs === val);
      end
      if (!hit) timeout_seen($sformatf("chip select never went to %0b", val));
   endtask

   task automatic wait_level(input int min_lvl);
      logic [15:0] d;
      int          n;
      bit          hit;
      hit = 0;
      for (n = 0; n < 3000 && !hit; n++) begin
         bus_read(REG_STATUS, d);
         if (d[7:0] >= min_lvl) hit = 1;
      end
      if (!hit) timeout_seen($sformatf("FIFO level never reached %0d", min_lvl));
   endtask

   // each word checked whole with its tag in the top bits
   task automatic read_words(input int count);
      logic [15:0] d;
      for (int i = 0; i < count; i++) begin
         bus_read(REG_DATA, d);
         check_val($sformatf("data word %0d", i), d, exp_word[i % 3]);
      end
   endtask

   task automatic fifo_drain();
      logic [15:0] d;
      int          lvl;
      bus_write(REG_CTRL, 16'h0000);
      wait_ncs(1'b1, 2000);
      bus_read(REG_STATUS, d);
      lvl = d[7:0];
      repeat (lvl) bus_read(REG_DATA, d);
      bus_read(REG_STATUS, d); // also clears overflow
   endtask

   task automatic load_sensor_bytes();
      logic [7:0] raw [6];
      for (int i = 0; i < 6; i++) begin
         raw[i] = 8'($random(seed));
         u_sensor.mem[XDATA_ADDR + i] = raw[i];
      end
      // low byte at the bottom with six value bits of the high byte above it
      for (int a = 0; a < 3; a++) begin
         exp_word[a] = {2'(a), raw[2*a+1][5:0], raw[2*a]};
      end
   endtask

   task automatic test_reset_state();
      logic [15:0] d;
      check_val("ncs_o", 16'(ncs), 16'd1);
      check_val("sck_o", 16'(sck), 16'd0);
      check_val("irq_o", 16'(irq), 16'd0);
      bus_read(REG_STATUS, d);
      check_val("status level", 16'(d[7:0]), 16'd0);
   endtask

   task automatic test_single_sample();
      logic [15:0] d;
      bus_write(REG_CTRL, 16'h0011); // enable, divider 1
      wait_level(3);
      bus_write(REG_CTRL, 16'h0000);
      wait_ncs(1'b1, 2000);
      check_val("sensor command byte", 16'(u_sensor.cmd), 16'h000B);
      read_words(3);
      bus_read(REG_STATUS, d);
      check_val("status last tag", 16'(d[13:12]), 16'd2);
      fifo_drain();
   endtask

   task automatic test_divider();
      int   run;
      int   highs;
      int   n;
      logic prev;
      bus_write(REG_CTRL, 16'h0031);
      wait_ncs(1'b0, 1000);
      prev  = sck;
      run   = 1;
      highs = 0;
      n     = 0;
      while (ncs === 1'b0 && n < 2000) begin
         @(posedge clk);
         #1;
         n++;
         if (sck !== prev) begin
            if (prev) begin
               check_val("sck high cycles", 16'(run), 16'd4);
               highs++;
            end else if (highs % 8 != 0) begin
               check_val("sck low cycles", 16'(run), 16'd4); // gaps between bytes skipped
            end
            run  = 1;
            prev = sck;
         end else begin
            run++;
         end
      end
      if (n >= 2000) timeout_seen("burst with divider 3 never ended");
      check_val("sck pulses per burst", 16'(highs), 16'd64);
      bus_write(REG_CTRL, 16'h0000);
      wait_ncs(1'b1, 2000);
      read_words(3);
      fifo_drain();
   endtask

   task automatic test_interrupt();
      logic [15:0] d;
      int          lvl;
      int          n;
      bus_write(REG_THRESH, 16'd3);
      check_val("irq_o", 16'(irq), 16'd0);
      bus_write(REG_CTRL, 16'h0011);
      for (n = 0; n < 2000 && irq !== 1'b1; n++) begin
         @(posedge clk);
         #1;
      end
      if (irq !== 1'b1) timeout_seen("irq_o never rose");
      bus_read(REG_STATUS, d);
      check_val("status level at irq rise", 16'(d[7:0]), 16'd3);
      bus_write(REG_CTRL, 16'h0000);
      wait_ncs(1'b1, 2000);
      bus_read(REG_STATUS, d);
      lvl = d[7:0];
      check_val("irq_o", 16'(irq), 16'd1);
      repeat (lvl - 2) bus_read(REG_DATA, d); // leaves two words
      check_val("irq_o", 16'(irq), 16'd0);
      bus_write(REG_THRESH, 16'd0);
      fifo_drain();
   endtask

   task automatic test_overflow();
      logic [15:0] d;
      bus_read(REG_STATUS, d);
      check_val("status overflow", 16'(d[8]), 16'd0);
      bus_write(REG_CTRL, 16'h0011);
      wait_level(FIFO_DEPTH);
      // let the current burst end and then run one full burst into a full FIFO
      wait_ncs(1'b1, 2000);
      wait_ncs(1'b0, 1000);
      wait_ncs(1'b1, 2000);
      bus_write(REG_CTRL, 16'h0000);
      bus_read(REG_STATUS, d);
      check_val("status overflow", 16'(d[8]), 16'd1);
      check_val("status level", 16'(d[7:0]), 16'(FIFO_DEPTH));
      bus_read(REG_STATUS, d);
      check_val("status overflow", 16'(d[8]), 16'd0);
      read_words(FIFO_DEPTH);
   endtask

   task automatic test_empty_read();
      logic [15:0] d;
      bus_read(REG_DATA, d);
      check_val("empty data read", d, 16'h0000);
      bus_read(REG_STATUS, d);
      check_val("status level", 16'(d[7:0]), 16'd0);
   endtask

   initial begin
      seed     = 82;
      n_checks = 0;
      n_err    = 0;
      n_tmo    = 0;
      n_asrt   = 0;
      rst_n    = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = 2'd0;
      wdata    = 16'h0000;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      load_sensor_bytes();
      test_reset_state();
      test_single_sample();
      test_divider();
      test_interrupt();
      test_overflow();
      test_empty_read();
      n_asrt = u_dut.u_assert.n_fail;
      $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
               n_checks, n_err, n_tmo, n_asrt);
      if (n_err == 0 && n_tmo == 0 && n_asrt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== logic/accel_host_port.sv ====
`timescale 1ns/1ps

module accel_host_port #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            bus_stb_i,
   input  logic                            bus_we_i,
   input  logic [1:0]                      bus_adr_i,
   input  logic [15:0]                     bus_wdata_i,
   input  accel_pkg::axis_word_u           head_word_i,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] level_i,
   input  logic                            overflow_i,
   output logic                            bus_ack_o,
   output logic [15:0]                     bus_rdata_o,
   output logic                            enable_o,
   output logic [accel_pkg::DIV_W-1:0]     div_o,
   output logic                            pop_o,
   output logic                            irq_o
);

   import accel_pkg::*;

   localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

   logic             rd_stb;
   logic             wr_stb;
   logic             ctrl_en;
   logic [DIV_W-1:0] ctrl_div;
   logic [LVL_W-1:0] thresh;
   logic             ovf_sticky;
   logic [TAG_W-1:0] last_tag;   // tag of the most recent pop
   logic             ack_q;
   logic [15:0]      rdata_q;
   logic [15:0]      rd_mux;

   assign rd_stb = bus_stb_i && !bus_we_i;
   assign wr_stb = bus_stb_i && bus_we_i;

   // a DATA read on an empty FIFO pops nothing
   assign pop_o = rd_stb && (bus_adr_i == REG_DATA) && (level_i != '0);

   always_comb begin
      rd_mux = '0;
      case (bus_adr_i)
         REG_CTRL: begin
            rd_mux[CTRL_EN_BIT]           = ctrl_en;
            rd_mux[CTRL_DIV_LSB +: DIV_W] = ctrl_div;
         end
         REG_STATUS: begin
            rd_mux[LVL_W-1:0]             = level_i;
            rd_mux[STAT_OVF_BIT]          = ovf_sticky;
            rd_mux[STAT_TAG_LSB +: TAG_W] = last_tag;
         end
         REG_DATA: begin
            if (level_i != '0) rd_mux = head_word_i.raw; // whole word, tag included
         end
         REG_THRESH: rd_mux[LVL_W-1:0] = thresh;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_en    <= 1'b0;
         ctrl_div   <= '0;
         thresh     <= '0;
         ovf_sticky <= 1'b0;
         last_tag   <= '0;
         ack_q      <= 1'b0;
         rdata_q    <= '0;
      end else begin
         ack_q   <= bus_stb_i;                // fixed one cycle acknowledge
         rdata_q <= rd_stb ? rd_mux : '0;
         if (wr_stb && bus_adr_i == REG_CTRL) begin
            ctrl_en  <= bus_wdata_i[CTRL_EN_BIT];
            ctrl_div <= bus_wdata_i[CTRL_DIV_LSB +: DIV_W];
         end
         if (wr_stb && bus_adr_i == REG_THRESH) thresh <= bus_wdata_i[LVL_W-1:0];
         // a new drop wins over the clear on read
         if (overflow_i) begin
            ovf_sticky <= 1'b1;
         end else if (rd_stb && bus_adr_i == REG_STATUS) begin
            ovf_sticky <= 1'b0;
         end
         if (pop_o) last_tag <= head_word_i.sample.tag;
      end
   end

   assign bus_ack_o   = ack_q;
   assign bus_rdata_o = rdata_q;
   assign enable_o    = ctrl_en;
   assign div_o       = ctrl_div;
   assign irq_o       = (thresh != '0) && (level_i >= thresh); // zero threshold disables

endmodule

// ==== logic/accel_pkg.sv ====
package accel_pkg;

   // field widths
   localparam int DIV_W  = 4;
   localparam int TAG_W  = 2;
   localparam int VAL_W  = 14;
   localparam int WORD_W = TAG_W + VAL_W;

   // axis tags carried in the upper bits of each FIFO word
   localparam logic [TAG_W-1:0] TAG_X = 2'd0;
   localparam logic [TAG_W-1:0] TAG_Y = 2'd1;
   localparam logic [TAG_W-1:0] TAG_Z = 2'd2;

   // host register map
   localparam logic [1:0] REG_CTRL   = 2'd0;
   localparam logic [1:0] REG_STATUS = 2'd1;
   localparam logic [1:0] REG_DATA   = 2'd2;
   localparam logic [1:0] REG_THRESH = 2'd3;

   // bit positions inside CTRL and STATUS
   localparam int CTRL_EN_BIT  = 0;
   localparam int CTRL_DIV_LSB = 4;
   localparam int STAT_OVF_BIT = 8;
   localparam int STAT_TAG_LSB = 12;

   // sensor side
   localparam logic [7:0] CMD_READ   = 8'h0B;
   localparam logic [7:0] XDATA_ADDR = 8'h0E; // XDATA_L, then auto increment

   // one FIFO word, seen as raw data or as tag plus sample
   typedef union packed {
      logic [WORD_W-1:0] raw;
      struct packed {
         logic [TAG_W-1:0] tag;
         logic [VAL_W-1:0] value;
      } sample;
   } axis_word_u;

endpackage

// ==== logic/accel_sampler.sv ====
`timescale 1ns/1ps

module accel_sampler #(
   parameter int SAMPLE_PERIOD = 2000
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  enable_i,
   input  logic                  byte_done_i,
   input  logic [7:0]            rx_byte_i,
   output logic                  byte_start_o,
   output logic [7:0]            tx_byte_o,
   output logic                  ncs_o,
   output logic                  push_o,
   output accel_pkg::axis_word_u push_word_o
);

   import accel_pkg::*;

   localparam int TMR_W = $clog2(SAMPLE_PERIOD + 1);

   // burst sequencer states
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_LOAD = 2'd1;
   localparam logic [1:0] ST_WAIT = 2'd2;

   logic [TMR_W-1:0] tmr;
   logic             period_hit;
   logic             burst_go;
   logic [1:0]       state;
   logic [2:0]       byte_idx;  // 0 cmd, 1 addr, 2..7 data
   logic             start_q;
   logic [7:0]       tx_q;
   logic             ncs_q;
   logic [7:0]       lo_byte;
   logic             hi_byte;
   axis_word_u       word;

   assign period_hit = (tmr == TMR_W'(SAMPLE_PERIOD - 1));
   assign burst_go   = enable_i && period_hit && (state == ST_IDLE);

   // sample period timer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tmr <= '0;
      end else if (!enable_i) begin
         tmr <= '0;
      end else if (burst_go) begin
         tmr <= '0;              // restarts as the burst begins
      end else if (!period_hit) begin
         tmr <= tmr + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= ST_IDLE;
         byte_idx <= '0;
         start_q  <= 1'b0;
         ncs_q    <= 1'b1;
      end else begin
         start_q <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (burst_go) begin
                  ncs_q    <= 1'b0;
                  byte_idx <= '0;
                  state    <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               start_q <= 1'b1;
               state   <= ST_WAIT;
            end
            ST_WAIT: begin
               if (byte_done_i) begin
                  if (byte_idx == 3'd7) begin
                     ncs_q <= 1'b1;   // end of burst
                     state <= ST_IDLE;
                  end else begin
                     byte_idx <= byte_idx + 3'd1;
                     state    <= ST_LOAD;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // outgoing byte and captured low bytes
   always_ff @(posedge clk_i) begin
      if (state == ST_LOAD) begin
         case (byte_idx)
            3'd0:    tx_q <= CMD_READ;
            3'd1:    tx_q <= XDATA_ADDR;
            default: tx_q <= 8'h00;    // dummy, clocks data out of the sensor
         endcase
      end
      if (state == ST_WAIT && byte_done_i && byte_idx >= 3'd2 && !byte_idx[0]) begin
         lo_byte <= rx_byte_i;
      end
   end

   // high bytes sit at odd indices 3, 5, 7
   assign hi_byte = (state == ST_WAIT) && byte_done_i && byte_idx[0] && (byte_idx[2:1] != 2'd0);

   always_comb begin
      word.raw = '0;
      case (byte_idx[2:1])
         2'd1:    word.sample.tag = TAG_X;
         2'd2:    word.sample.tag = TAG_Y;
         default: word.sample.tag = TAG_Z;
      endcase
      word.sample.value = {rx_byte_i[5:0], lo_byte}; // 12 bit data plus sign ext bits
   end

   assign byte_start_o = start_q;
   assign tx_byte_o    = tx_q;
   assign ncs_o        = ncs_q;
   assign push_o       = hi_byte;
   assign push_word_o  = word;

endmodule

// ==== logic/accel_spi_top.sv ====
`timescale 1ns/1ps

module accel_spi_top #(
   parameter int FIFO_DEPTH    = 8,
   parameter int SAMPLE_PERIOD = 2000
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        bus_stb_i,
   input  logic        bus_we_i,
   input  logic [1:0]  bus_adr_i,
   input  logic [15:0] bus_wdata_i,
   input  logic        miso_i,
   output logic        bus_ack_o,
   output logic [15:0] bus_rdata_o,
   output logic        irq_o,
   output logic        sck_o,
   output logic        mosi_o,
   output logic        ncs_o
);

   import accel_pkg::*;

   logic                            enable;
   logic [DIV_W-1:0]                div;
   logic                            byte_start;
   logic [7:0]                      tx_byte;
   logic                            byte_done;
   logic [7:0]                      rx_byte;
   logic                            push;
   axis_word_u                      push_word;
   logic                            pop;
   axis_word_u                      head_word;
   logic [$clog2(FIFO_DEPTH+1)-1:0] level;
   logic                            overflow;

   spi_byte_engine u_engine (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .div_i        (div),
      .byte_start_i (byte_start),
      .tx_byte_i    (tx_byte),
      .miso_i       (miso_i),
      .sck_o        (sck_o),
      .mosi_o       (mosi_o),
      .byte_done_o  (byte_done),
      .rx_byte_o    (rx_byte)
   );

   accel_sampler #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) u_sampler (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .enable_i     (enable),
      .byte_done_i  (byte_done),
      .rx_byte_i    (rx_byte),
      .byte_start_o (byte_start),
      .tx_byte_o    (tx_byte),
      .ncs_o        (ncs_o),
      .push_o       (push),
      .push_word_o  (push_word)
   );

   sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (push),
      .push_word_i  (push_word),
      .pop_i        (pop),
      .head_word_o  (head_word),
      .level_o      (level),
      .overflow_o   (overflow)
   );

   accel_host_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_host (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .bus_stb_i    (bus_stb_i),
      .bus_we_i     (bus_we_i),
      .bus_adr_i    (bus_adr_i),
      .bus_wdata_i  (bus_wdata_i),
      .head_word_i  (head_word),
      .level_i      (level),
      .overflow_i   (overflow),
      .bus_ack_o    (bus_ack_o),
      .bus_rdata_o  (bus_rdata_o),
      .enable_o     (enable),
      .div_o        (div),
      .pop_o        (pop),
      .irq_o        (irq_o)
   );

endmodule

// ==== logic/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               push_i,
   input  accel_pkg::axis_word_u              push_word_i,
   input  logic                               pop_i,
   output accel_pkg::axis_word_u              head_word_o,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]    level_o,
   output logic                               overflow_o
);

   import accel_pkg::*;

   localparam int LVL_W = $clog2(FIFO_DEPTH + 1);
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   axis_word_u       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [LVL_W-1:0] level;
   logic             full;
   logic             empty;
   logic             do_push;
   logic             do_pop;
   logic             ovf_q;

   // wraps for any depth, not only powers of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (level == LVL_W'(FIFO_DEPTH));
   assign empty   = (level == '0);
   assign do_push = push_i && !full;   // dropped when full
   assign do_pop  = pop_i && !empty;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
         ovf_q  <= 1'b0;
      end else begin
         ovf_q <= push_i && full;
         if (do_push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
         if (do_push && !do_pop) begin
            level <= level + 1'b1;
         end else if (do_pop && !do_push) begin
            level <= level - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) mem[wr_ptr] <= push_word_i;
   end

   assign head_word_o = mem[rd_ptr];
   assign level_o     = level;
   assign overflow_o  = ovf_q;

endmodule

// ==== logic/spi_byte_engine.sv ====
`timescale 1ns/1ps

module spi_byte_engine (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic [accel_pkg::DIV_W-1:0] div_i,
   input  logic                        byte_start_i,
   input  logic [7:0]                  tx_byte_i,
   input  logic                        miso_i,
   output logic                        sck_o,
   output logic                        mosi_o,
   output logic                        byte_done_o,
   output logic [7:0]                  rx_byte_o
);

   import accel_pkg::*;

   logic             busy;
   logic [DIV_W-1:0] div_q;     // divider frozen for the whole byte
   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       edge_cnt;  // 16 sck edges per byte
   logic             sck_q;
   logic             done_q;
   logic [7:0]       tx_sr;
   logic [7:0]       rx_sr;
   logic             phase_end;

   // last cycle of the current sck half period
   assign phase_end = busy && (div_cnt == div_q);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy     <= 1'b0;
         div_q    <= '0;
         div_cnt  <= '0;
         edge_cnt <= '0;
         sck_q    <= 1'b0;
         done_q   <= 1'b0;
         tx_sr    <= '0;
      end else begin
         done_q <= 1'b0;
         if (!busy) begin
            // start requests while busy are simply not looked at
            if (byte_start_i) begin
               busy     <= 1'b1;
               div_q    <= div_i;
               div_cnt  <= '0;
               edge_cnt <= '0;
               tx_sr    <= tx_byte_i; // msb goes out before the first rise
            end
         end else if (phase_end) begin
            div_cnt  <= '0;
            sck_q    <= ~sck_q;
            edge_cnt <= edge_cnt + 4'd1;
            if (sck_q) begin
               // falling edge, next bit onto mosi
               tx_sr <= {tx_sr[6:0], 1'b0};
               if (edge_cnt == 4'd15) begin
                  busy   <= 1'b0;
                  done_q <= 1'b1;
               end
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // miso sampled as sck rises
   always_ff @(posedge clk_i) begin
      if (phase_end && !sck_q) begin
         rx_sr <= {rx_sr[6:0], miso_i};
      end
   end

   assign sck_o       = sck_q;
   assign mosi_o      = tx_sr[7];
   assign byte_done_o = done_q;
   assign rx_byte_o   = rx_sr; // complete when byte_done_o is high

endmodule
